/* exu.f */
+incdir+dv
design/exu_pkg.sv
design/ex_stage_if.sv
design/alu_req_if.sv
design/exu_stage_reg.sv
design/exu_decode.sv
design/exu_alu.sv
design/exu_result.sv
design/exu_top.sv
dv/exu_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := exu_tb
FLIST     := exu.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(filter-out +%,$(shell cat $(FLIST))) dv/exu_ref.svh

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

/* dv/exu_ref.svh */
`ifndef exu_ref_svh
`define exu_ref_svh

// mcause code of an environment call from m-mode
localparam xword_t ecall_m_cause = 64'd11;

function automatic xword_t sext_word(input logic [31:0] w);
    return {{32{w[31]}}, w};
endfunction

// expected alu_output, returns 0 where the op defines none
function automatic logic exp_alu(input exu_op_e op, input xword_t pc, input inst_t inst,
                                 input xword_t a, input xword_t b, input xword_t imm,
                                 output xword_t res);
    logic [5:0] sh;
    logic [4:0] shw;
    // shamt field, 6 bits for rv64, 5 for word forms
    sh  = inst[25:20];
    shw = inst[24:20];
    res = '0;
    case (op)
        op_add:   res = a + b;
        op_sub:   res = a - b;
        op_sll:   res = a << b[5:0];
        op_srl:   res = a >> b[5:0];
        op_slt:   res = xword_t'($signed(a) < $signed(b));
        op_sltu:  res = xword_t'(a < b);
        op_xor:   res = a ^ b;
        op_or:    res = a | b;
        op_and:   res = a & b;
        op_addi:  res = a + imm;
        op_slti:  res = xword_t'($signed(a) < $signed(imm));
        op_sltiu: res = xword_t'(a < imm);
        op_xori:  res = a ^ imm;
        op_ori:   res = a | imm;
        op_andi:  res = a & imm;
        op_slli:  res = a << sh;
        op_srli:  res = a >> sh;
        op_srai:  res = xword_t'($signed(a) >>> sh);
        op_lui:   res = imm;
        op_auipc: res = pc + imm;
        // effective address only
        op_lb, op_lh, op_lw, op_lbu, op_lhu, op_lwu, op_ld, op_sb, op_sh, op_sw, op_sd: begin
            res = a + imm;
        end
        // word ops work on the low 32 bits
        op_addw:  res = sext_word(a[31:0] + b[31:0]);
        op_subw:  res = sext_word(a[31:0] - b[31:0]);
        op_sllw:  res = sext_word(a[31:0] << b[4:0]);
        op_srlw:  res = sext_word(a[31:0] >> b[4:0]);
        op_sraw:  res = sext_word($signed(a[31:0]) >>> b[4:0]);
        op_addiw: res = sext_word(a[31:0] + imm[31:0]);
        op_slliw: res = sext_word(a[31:0] << shw);
        op_srliw: res = sext_word(a[31:0] >> shw);
        op_sraiw: res = sext_word($signed(a[31:0]) >>> shw);
        // old csr value arrives on b
        op_csrrs: res = a | b;
        default:  return 1'b0;
    endcase
    return 1'b1;
endfunction

function automatic logic branch_taken(input exu_op_e op, input xword_t a, input xword_t b);
    case (op)
        op_beq:  return a == b;
        op_bne:  return a != b;
        op_blt:  return $signed(a) < $signed(b);
        op_bge:  return $signed(a) >= $signed(b);
        op_bltu: return a < b;
        op_bgeu: return a >= b;
        default: return 1'b0;
    endcase
endfunction

function automatic xword_t exp_dnpc(input exu_op_e op, input xword_t pc, input xword_t a,
                                    input xword_t b, input xword_t imm);
    case (op)
        op_jal:  return pc + imm;
        op_jalr: return (a + imm) & ~64'd1;
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: begin
            return branch_taken(op, a, b) ? pc + imm : pc + 64'd4;
        end
        // trap vector or mepc supplied on b
        op_ecall, op_mret: return b;
        default: return pc + 64'd4;
    endcase
endfunction

function automatic logic exp_pc_update(input exu_op_e op);
    case (op)
        op_jal, op_jalr, op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_ecall, op_mret: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

// strobes in the order mtvec, mepc, mcause, mstatus
function automatic logic [3:0] exp_wen(input exu_op_e op, input inst_t inst);
    logic [3:0] hit;
    hit = {inst[31:20] == csr_mtvec, inst[31:20] == csr_mepc,
           inst[31:20] == csr_mcause, inst[31:20] == csr_mstatus};
    if (op == op_ecall) return 4'b0110;
    if (op == op_csrrw || op == op_csrrs) return hit;
    return 4'b0000;
endfunction

// write data of an enabled csr
function automatic xword_t exp_csr_data(input exu_op_e op, input csr_addr_e csr,
                                        input xword_t pc, input xword_t a, input xword_t b);
    if (op == op_ecall) return (csr == csr_mepc) ? pc : ecall_m_cause;
    if (op == op_csrrs) return a | b;
    return a;
endfunction

`endif

/* dv/exu_tb.sv */
module exu_tb;

    import exu_pkg::*;

    // far above the ~1500 cycles the tests take
    localparam int timeout_cycles = 4000;

    logic    clk;
    logic    rst;
    logic    valid_id_ex;
    xword_t  pc_id_ex;
    inst_t   inst_id_ex;
    exu_op_e opcode_in;
    xword_t  src_a;
    xword_t  src_b;
    xword_t  imm_in;
    logic    ready_ex_mem;
    logic    ready_id_ex;
    logic    valid_ex_mem;
    xword_t  pc_ex_mem;
    inst_t   inst_ex_mem;
    exu_op_e opcode_ex_mem;
    xword_t  alu_output;
    xword_t  src_b_ex_mem;
    xword_t  dnpc;
    logic    pc_update;
    xword_t  wdata_mtvec;
    xword_t  wdata_mepc;
    xword_t  wdata_mcause;
    xword_t  wdata_mstatus;
    logic    wen_mtvec;
    logic    wen_mepc;
    logic    wen_mcause;
    logic    wen_mstatus;

    int          cycles = 0;
    logic [31:0] lfsr_state = 32'ha55ce229;
    // outputs frozen at the start of a stall
    xword_t      held_out [9];

    exu_op_e alu_ops [29] = '{op_add, op_sub, op_sll, op_slt, op_sltu, op_xor, op_srl,
        op_or, op_and, op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi, op_slli,
        op_srli, op_srai, op_lb, op_lh, op_lw, op_lbu, op_lhu, op_lwu, op_ld, op_sb,
        op_sh, op_sw, op_sd};
    exu_op_e word_ops [9] = '{op_addw, op_subw, op_sllw, op_srlw, op_sraw, op_addiw,
        op_slliw, op_srliw, op_sraiw};
    exu_op_e branch_ops [6] = '{op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};
    csr_addr_e csr_list [4] = '{csr_mstatus, csr_mtvec, csr_mepc, csr_mcause};

    `include "exu_ref.svh"

    exu_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout: tests still running after %0d cycles", cycles);
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    // one lfsr step per bit
    function automatic xword_t rand_bits(input int n);
        xword_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic xword_t rand_imm();
        xword_t v;
        v = rand_bits(12);
        return {{52{v[11]}}, v[11:0]};
    endfunction

    function automatic inst_t rand_inst();
        xword_t v;
        v = rand_bits(32);
        return v[31:0];
    endfunction

    task automatic check_eq(input xword_t got, input xword_t exp, input string what);
        if (got !== exp) begin
            $display("Fail at time %0t: %s is %h, expected %h", $time, what, got, exp);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // called one unit after a rising edge
    task automatic drive(input logic valid, input exu_op_e op, input xword_t pc,
                         input inst_t inst, input xword_t a, input xword_t b,
                         input xword_t imm);
        valid_id_ex = valid;
        opcode_in   = op;
        pc_id_ex    = pc;
        inst_id_ex  = inst;
        src_a       = a;
        src_b       = b;
        imm_in      = imm;
    endtask

    // one instruction through the stage, all outputs checked a cycle later
    task automatic run_op(input logic valid, input exu_op_e op, input xword_t pc,
                          input inst_t inst, input xword_t a, input xword_t b,
                          input xword_t imm);
        exu_op_e    eff_op;
        xword_t     exp_res;
        logic [3:0] exp_w;
        drive(valid, op, pc, inst, a, b, imm);
        @(posedge clk);
        #1;
        // a bubble travels as the empty opcode
        eff_op = valid ? op : op_empty;
        exp_w  = exp_wen(eff_op, inst);
        // ready passes straight through from the mem stage
        check_eq(xword_t'(ready_id_ex), xword_t'(ready_ex_mem), "ready_id_ex");
        check_eq(xword_t'(valid_ex_mem), xword_t'(valid), "valid_ex_mem");
        check_eq(xword_t'(opcode_ex_mem), xword_t'(eff_op), "opcode_ex_mem");
        check_eq(pc_ex_mem, pc, "pc_ex_mem");
        check_eq(xword_t'(inst_ex_mem), xword_t'(inst), "inst_ex_mem");
        check_eq(src_b_ex_mem, b, "src_b_ex_mem");
        if (exp_alu(eff_op, pc, inst, a, b, imm, exp_res)) begin
            check_eq(alu_output, exp_res, "alu_output");
        end
        check_eq(dnpc, exp_dnpc(eff_op, pc, a, b, imm), "dnpc");
        check_eq(xword_t'(pc_update), xword_t'(exp_pc_update(eff_op)), "pc_update");
        check_eq(xword_t'({wen_mtvec, wen_mepc, wen_mcause, wen_mstatus}), xword_t'(exp_w),
                 "csr strobes");
        if (exp_w[3]) check_eq(wdata_mtvec, exp_csr_data(eff_op, csr_mtvec, pc, a, b), "mtvec");
        if (exp_w[2]) check_eq(wdata_mepc, exp_csr_data(eff_op, csr_mepc, pc, a, b), "mepc");
        if (exp_w[1]) check_eq(wdata_mcause, exp_csr_data(eff_op, csr_mcause, pc, a, b),
                               "mcause");
        if (exp_w[0]) check_eq(wdata_mstatus, exp_csr_data(eff_op, csr_mstatus, pc, a, b),
                               "mstatus");
    endtask

    // every output folded into 64-bit words
    function automatic xword_t output_word(input int i);
        case (i)
            0: return xword_t'({valid_ex_mem, pc_update, wen_mtvec, wen_mepc, wen_mcause,
                               wen_mstatus, opcode_ex_mem, inst_ex_mem});
            1: return pc_ex_mem;
            2: return alu_output;
            3: return src_b_ex_mem;
            4: return dnpc;
            5: return wdata_mtvec;
            6: return wdata_mepc;
            7: return wdata_mcause;
            8: return wdata_mstatus;
            default: return '0;
        endcase
    endfunction

    task automatic test_reset();
        check_eq(xword_t'(valid_ex_mem), 64'd0, "valid_ex_mem after reset");
        check_eq(xword_t'(pc_update), 64'd0, "pc_update after reset");
        check_eq(xword_t'({wen_mtvec, wen_mepc, wen_mcause, wen_mstatus}), 64'd0,
                 "csr strobes after reset");
        // bubble with an ecall code must stay silent
        run_op(1'b0, op_ecall, rand_bits(64), rand_inst(), rand_bits(64), rand_bits(64),
               rand_imm());
    endtask

    task automatic test_alu_ops();
        xword_t a;
        xword_t b;
        xword_t imm;
        xword_t uimm;
        xword_t pc;
        inst_t  inst;
        for (int n = 0; n < 40; n++) begin
            a    = rand_bits(64);
            b    = rand_bits(64);
            imm  = rand_imm();
            pc   = rand_bits(64) & ~64'd3;
            inst = rand_inst();
            // u-type immediate, low 12 bits clear
            uimm = rand_bits(20) << 12;
            uimm = {{32{uimm[31]}}, uimm[31:0]};
            foreach (alu_ops[i]) run_op(1'b1, alu_ops[i], pc, inst, a, b, imm);
            run_op(1'b1, op_lui, pc, inst, a, b, uimm);
            run_op(1'b1, op_auipc, pc, inst, a, b, uimm);
        end
    endtask

    task automatic test_word_ops();
        for (int n = 0; n < 20; n++) begin
            foreach (word_ops[i]) begin
                run_op(1'b1, word_ops[i], rand_bits(64), rand_inst(), rand_bits(64),
                       rand_bits(64), rand_imm());
            end
        end
    endtask

    task automatic test_control_flow();
        xword_t lhs [5];
        xword_t rhs [5];
        xword_t x;
        x = rand_bits(64);
        // equal, less, greater, then signed and unsigned disagreeing
        lhs = '{x, 64'd5, 64'd9, '1, 64'd1};
        rhs = '{x, 64'd9, 64'd5, 64'd1, '1};
        foreach (branch_ops[i]) begin
            foreach (lhs[k]) begin
                run_op(1'b1, branch_ops[i], rand_bits(64) & ~64'd3, rand_inst(), lhs[k],
                       rhs[k], rand_imm() & ~64'd1);
            end
        end
        repeat (4) begin
            run_op(1'b1, op_jal, rand_bits(64), rand_inst(), rand_bits(64), rand_bits(64),
                   rand_imm());
            run_op(1'b1, op_jalr, rand_bits(64), rand_inst(), rand_bits(64), rand_bits(64),
                   rand_imm());
        end
    endtask

    task automatic test_csr_ops();
        xword_t r;
        inst_t  inst;
        foreach (csr_list[i]) begin
            r    = rand_bits(20);
            inst = {csr_list[i], r[19:0]};
            run_op(1'b1, op_csrrw, rand_bits(64), inst, rand_bits(64), rand_bits(64), '0);
            run_op(1'b1, op_csrrs, rand_bits(64), inst, rand_bits(64), rand_bits(64), '0);
        end
        run_op(1'b1, op_ecall, rand_bits(64), rand_inst(), rand_bits(64), rand_bits(64), '0);
        run_op(1'b1, op_mret, rand_bits(64), rand_inst(), rand_bits(64), rand_bits(64), '0);
    endtask

    task automatic test_back_pressure();
        run_op(1'b1, op_add, rand_bits(64), rand_inst(), rand_bits(64), rand_bits(64),
               rand_imm());
        foreach (held_out[i]) held_out[i] = output_word(i);
        ready_ex_mem = 1'b0;
        // new inputs every cycle, nothing may move
        repeat (5) begin
            drive(1'b1, op_ecall, rand_bits(64), rand_inst(), rand_bits(64), rand_bits(64),
                  rand_imm());
            @(posedge clk);
            #1;
            check_eq(xword_t'(ready_id_ex), 64'd0, "ready_id_ex under stall");
            foreach (held_out[i]) check_eq(output_word(i), held_out[i], "held output");
        end
        ready_ex_mem = 1'b1;
        run_op(1'b1, op_sub, rand_bits(64), rand_inst(), rand_bits(64), rand_bits(64),
               rand_imm());
    endtask

    initial begin
        rst          = 1'b1;
        ready_ex_mem = 1'b1;
        drive(1'b0, op_empty, '0, '0, '0, '0, '0);
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset();
        test_alu_ops();
        test_word_ops();
        test_control_flow();
        test_csr_ops();
        test_back_pressure();
        $display(">>> PASS");
        $finish;
    end

endmodule

/* design/exu_top.sv */
module exu_top #(
    parameter exu_pkg::xword_t ecall_cause = 64'd11
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              valid_id_ex,
    input  exu_pkg::xword_t   pc_id_ex,
    input  exu_pkg::inst_t    inst_id_ex,
    input  exu_pkg::exu_op_e  opcode_in,
    input  exu_pkg::xword_t   src_a,
    input  exu_pkg::xword_t   src_b,
    input  exu_pkg::xword_t   imm_in,
    input  logic              ready_ex_mem,
    output logic              ready_id_ex,
    output logic              valid_ex_mem,
    output exu_pkg::xword_t   pc_ex_mem,
    output exu_pkg::inst_t    inst_ex_mem,
    output exu_pkg::exu_op_e  opcode_ex_mem,
    output exu_pkg::xword_t   alu_output,
    output exu_pkg::xword_t   src_b_ex_mem,
    output exu_pkg::xword_t   dnpc,
    output logic              pc_update,
    output exu_pkg::xword_t   wdata_mtvec,
    output exu_pkg::xword_t   wdata_mepc,
    output exu_pkg::xword_t   wdata_mcause,
    output exu_pkg::xword_t   wdata_mstatus,
    output logic              wen_mtvec,
    output logic              wen_mepc,
    output logic              wen_mcause,
    output logic              wen_mstatus
);

    import exu_pkg::*;

    xword_t alu_result;

    ex_stage_if stage_bus (.clk(clk));
    alu_req_if  req_bus ();

    // id/ex register, one cycle
    exu_stage_reg u_stage_reg (
        .clk           (clk),
        .rst           (rst),
        .valid_id_ex   (valid_id_ex),
        .pc_id_ex      (pc_id_ex),
        .inst_id_ex    (inst_id_ex),
        .opcode_in     (opcode_in),
        .src_a         (src_a),
        .src_b         (src_b),
        .imm_in        (imm_in),
        .ready_ex_mem  (ready_ex_mem),
        .ready_id_ex   (ready_id_ex),
        .valid_ex_mem  (valid_ex_mem),
        .pc_ex_mem     (pc_ex_mem),
        .inst_ex_mem   (inst_ex_mem),
        .opcode_ex_mem (opcode_ex_mem),
        .src_b_ex_mem  (src_b_ex_mem),
        .stage         (stage_bus.stage)
    );

    // the rest is combinational behind the register
    exu_decode u_decode (
        .stage (stage_bus.sink),
        .req   (req_bus.req)
    );

    exu_alu u_alu (
        .req    (req_bus.alu),
        .result (alu_result)
    );

    exu_result #(
        .ecall_cause (ecall_cause)
    ) u_result (
        .stage         (stage_bus.sink),
        .req           (req_bus.user),
        .alu_result    (alu_result),
        .alu_output    (alu_output),
        .dnpc          (dnpc),
        .pc_update     (pc_update),
        .wdata_mtvec   (wdata_mtvec),
        .wdata_mepc    (wdata_mepc),
        .wdata_mcause  (wdata_mcause),
        .wdata_mstatus (wdata_mstatus),
        .wen_mtvec     (wen_mtvec),
        .wen_mepc      (wen_mepc),
        .wen_mcause    (wen_mcause),
        .wen_mstatus   (wen_mstatus)
    );

endmodule

/* design/exu_result.sv */
module exu_result #(
    parameter exu_pkg::xword_t ecall_cause = 64'd11
) (
    ex_stage_if.sink        stage,
    alu_req_if.user         req,
    input  exu_pkg::xword_t alu_result,
    output exu_pkg::xword_t alu_output,
    output exu_pkg::xword_t dnpc,
    output logic            pc_update,
    output exu_pkg::xword_t wdata_mtvec,
    output exu_pkg::xword_t wdata_mepc,
    output exu_pkg::xword_t wdata_mcause,
    output exu_pkg::xword_t wdata_mstatus,
    output logic            wen_mtvec,
    output logic            wen_mepc,
    output logic            wen_mcause,
    output logic            wen_mstatus
);

    import exu_pkg::*;

    xword_t      snpc;
    logic        taken;
    logic        is_ecall;
    logic        csr_write;
    logic [11:0] csr_sel;
    xword_t      csr_data;

    // word results back to 64 bits
    always_comb begin
        case (req.ext_kind)
            ext_sext_lo: alu_output = {{32{alu_result[31]}}, alu_result[31:0]};
            ext_sext_hi: alu_output = {{32{alu_result[63]}}, alu_result[63:32]};
            default:     alu_output = alu_result;
        endcase
    end

    assign snpc = stage.pc + pc_step;

    // branch condition straight from the register sources
    always_comb begin
        case (stage.op)
            op_beq:  taken = (stage.src_a == stage.src_b);
            op_bne:  taken = (stage.src_a != stage.src_b);
            op_blt:  taken = ($signed(stage.src_a) < $signed(stage.src_b));
            op_bge:  taken = ($signed(stage.src_a) >= $signed(stage.src_b));
            op_bltu: taken = (stage.src_a < stage.src_b);
            op_bgeu: taken = (stage.src_a >= stage.src_b);
            default: taken = 1'b0;
        endcase
    end

    // target is pc + imm from the alu for jal and branches
    always_comb begin
        pc_update = 1'b1;
        case (stage.op)
            op_jal:  dnpc = alu_result;
            op_jalr: dnpc = {alu_result[63:1], 1'b0};
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: begin
                dnpc = taken ? alu_result : snpc;
            end
            // trap vector or return address comes in on src_b
            op_ecall, op_mret: dnpc = stage.src_b;
            default: begin
                dnpc      = snpc;
                pc_update = 1'b0;
            end
        endcase
    end

    // csr writes
    assign is_ecall  = (stage.op == op_ecall);
    assign csr_write = (stage.op == op_csrrw) || (stage.op == op_csrrs);
    assign csr_sel   = stage.inst[31:20];
    // csrrs already ored in the alu
    assign csr_data  = (stage.op == op_csrrw) ? stage.src_a : alu_result;

    assign wen_mtvec   = csr_write && (csr_sel == csr_mtvec);
    assign wen_mstatus = csr_write && (csr_sel == csr_mstatus);
    assign wen_mepc    = is_ecall || (csr_write && (csr_sel == csr_mepc));
    assign wen_mcause  = is_ecall || (csr_write && (csr_sel == csr_mcause));

    assign wdata_mtvec   = csr_write ? csr_data : '0;
    assign wdata_mstatus = csr_write ? csr_data : '0;
    // ecall saves the trapping pc and its cause
    assign wdata_mepc    = is_ecall ? stage.pc : (csr_write ? csr_data : '0);
    assign wdata_mcause  = is_ecall ? ecall_cause : (csr_write ? csr_data : '0);

    // only ecall touches two csrs at once
    a_one_csr: assert property (
        @(posedge stage.clk) !is_ecall |->
            $onehot0({wen_mtvec, wen_mepc, wen_mcause, wen_mstatus})
    );

endmodule

/* design/exu_alu.sv */
module exu_alu (
    alu_req_if.alu          req,
    output exu_pkg::xword_t result
);

    import exu_pkg::*;

    logic [5:0] shamt;

    // only six bits of b matter for shifts
    assign shamt = req.operand_b[5:0];

    always_comb begin
        case (req.mode)
            alu_add:  result = req.operand_a + req.operand_b;
            alu_sub:  result = req.operand_a - req.operand_b;
            // compares give 0 or 1
            alu_slt: begin
                result = xword_t'($signed(req.operand_a) < $signed(req.operand_b));
            end
            alu_sltu: begin
                result = xword_t'(req.operand_a < req.operand_b);
            end
            alu_and:  result = req.operand_a & req.operand_b;
            alu_or:   result = req.operand_a | req.operand_b;
            alu_xor:  result = req.operand_a ^ req.operand_b;
            alu_sll:  result = req.operand_a << shamt;
            alu_srl:  result = req.operand_a >> shamt;
            // arithmetic, sign bit fills from the left
            alu_sra:  result = xword_t'($signed(req.operand_a) >>> shamt);
            default:  result = '0;
        endcase
    end

endmodule

/* design/exu_decode.sv */
module exu_decode (
    ex_stage_if.sink stage,
    alu_req_if.req   req
);

    import exu_pkg::*;

    xword_t word_lo;
    xword_t word_hi;
    xword_t sh_imm6;
    xword_t sh_imm5;
    xword_t sh_reg6;
    xword_t sh_reg5;
    logic   known_op;

    // low word zero-extended, or parked in the upper half for right shifts
    assign word_lo = {32'b0, stage.src_a[31:0]};
    assign word_hi = {stage.src_a[31:0], 32'b0};

    // shift amounts, shamt field or rs2 value
    assign sh_imm6 = xword_t'(stage.inst[25:20]);
    assign sh_imm5 = xword_t'(stage.inst[24:20]);
    assign sh_reg6 = xword_t'(stage.src_b[5:0]);
    assign sh_reg5 = xword_t'(stage.src_b[4:0]);

    always_comb begin
        // default is a plain add of the two sources
        req.mode      = alu_add;
        req.operand_a = stage.src_a;
        req.operand_b = stage.src_b;
        req.ext_kind  = ext_none;
        known_op      = 1'b1;
        case (stage.op)
            // only op_add uses the sum of these
            op_empty, op_add, op_csrrw, op_ecall, op_mret: begin
                req.mode = alu_add;
            end
            op_sub:  req.mode = alu_sub;
            op_slt:  req.mode = alu_slt;
            op_sltu: req.mode = alu_sltu;
            op_xor:  req.mode = alu_xor;
            op_or:   req.mode = alu_or;
            op_and:  req.mode = alu_and;
            // csr read value arrives on src_b
            op_csrrs: req.mode = alu_or;
            op_sll: begin
                req.mode      = alu_sll;
                req.operand_b = sh_reg6;
            end
            op_srl: begin
                req.mode      = alu_srl;
                req.operand_b = sh_reg6;
            end
            // address forms and addi, rs1 + imm
            op_addi, op_jalr, op_lb, op_lh, op_lw, op_lbu, op_lhu, op_lwu, op_ld,
            op_sb, op_sh, op_sw, op_sd: begin
                req.operand_b = stage.imm;
            end
            op_slti, op_sltiu, op_xori, op_ori, op_andi: begin
                req.operand_b = stage.imm;
                case (stage.op)
                    op_slti:  req.mode = alu_slt;
                    op_sltiu: req.mode = alu_sltu;
                    op_xori:  req.mode = alu_xor;
                    op_ori:   req.mode = alu_or;
                    default:  req.mode = alu_and;
                endcase
            end
            op_slli, op_srli, op_srai: begin
                req.operand_b = sh_imm6;
                case (stage.op)
                    op_slli: req.mode = alu_sll;
                    op_srli: req.mode = alu_srl;
                    default: req.mode = alu_sra;
                endcase
            end
            op_lui: begin
                req.operand_a = '0;
                req.operand_b = stage.imm;
            end
            // pc-relative targets
            op_auipc, op_jal, op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: begin
                req.operand_a = stage.pc;
                req.operand_b = stage.imm;
            end
            op_addw:  req.ext_kind = ext_sext_lo;
            op_subw: begin
                req.mode     = alu_sub;
                req.ext_kind = ext_sext_lo;
            end
            op_addiw: begin
                req.operand_b = stage.imm;
                req.ext_kind  = ext_sext_lo;
            end
            // left shift, low word of result is already right
            op_sllw, op_slliw: begin
                req.mode      = alu_sll;
                req.operand_b = (stage.op == op_sllw) ? sh_reg5 : sh_imm5;
                req.ext_kind  = ext_sext_lo;
            end
            op_srliw: begin
                req.mode      = alu_srl;
                req.operand_a = word_lo;
                req.operand_b = sh_imm5;
                req.ext_kind  = ext_sext_lo;
            end
            // right shifts in the upper half, result taken from bits 63:32
            op_srlw, op_sraw, op_sraiw: begin
                req.mode      = (stage.op == op_srlw) ? alu_srl : alu_sra;
                req.operand_a = word_hi;
                req.operand_b = (stage.op == op_sraiw) ? sh_imm5 : sh_reg5;
                req.ext_kind  = ext_sext_hi;
            end
            default: known_op = 1'b0;
        endcase
    end

    // upstream decode must only hand over codes this stage implements
    a_known_op: assert property (
        @(posedge stage.clk) stage.valid |-> known_op && !$isunknown(stage.op)
    );

endmodule

/* design/exu_stage_reg.sv */
module exu_stage_reg (
    input  logic              clk,
    input  logic              rst,
    input  logic              valid_id_ex,
    input  exu_pkg::xword_t   pc_id_ex,
    input  exu_pkg::inst_t    inst_id_ex,
    input  exu_pkg::exu_op_e  opcode_in,
    input  exu_pkg::xword_t   src_a,
    input  exu_pkg::xword_t   src_b,
    input  exu_pkg::xword_t   imm_in,
    input  logic              ready_ex_mem,
    output logic              ready_id_ex,
    output logic              valid_ex_mem,
    output exu_pkg::xword_t   pc_ex_mem,
    output exu_pkg::inst_t    inst_ex_mem,
    output exu_pkg::exu_op_e  opcode_ex_mem,
    output exu_pkg::xword_t   src_b_ex_mem,
    ex_stage_if.stage         stage
);

    import exu_pkg::*;

    logic    valid_q;
    exu_op_e op_q;
    xword_t  pc_q;
    inst_t   inst_q;
    xword_t  src_a_q;
    xword_t  src_b_q;
    xword_t  imm_q;

    // nothing here can stall, mem stage decides
    assign ready_id_ex = ready_ex_mem;

    // control part, a bubble loads the empty opcode
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            op_q    <= op_empty;
        end else if (ready_ex_mem) begin
            valid_q <= valid_id_ex;
            op_q    <= valid_id_ex ? opcode_in : op_empty;
        end
    end

    // payload, held under back-pressure
    always_ff @(posedge clk) begin
        if (ready_ex_mem) begin
            pc_q    <= pc_id_ex;
            inst_q  <= inst_id_ex;
            src_a_q <= src_a;
            src_b_q <= src_b;
            imm_q   <= imm_in;
        end
    end

    assign stage.valid = valid_q;
    assign stage.pc    = pc_q;
    assign stage.inst  = inst_q;
    assign stage.op    = op_q;
    assign stage.src_a = src_a_q;
    assign stage.src_b = src_b_q;
    assign stage.imm   = imm_q;

    // towards ex/mem
    assign valid_ex_mem  = valid_q;
    assign pc_ex_mem     = pc_q;
    assign inst_ex_mem   = inst_q;
    assign opcode_ex_mem = op_q;
    assign src_b_ex_mem  = src_b_q;

    // a stalled instruction must not change under the mem stage
    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (rst)
        !ready_ex_mem |=> $stable(valid_q) && $stable(op_q) &&
            (!valid_q || ($stable(pc_q) && $stable(inst_q) && $stable(src_a_q) &&
                          $stable(src_b_q) && $stable(imm_q)))
    );

endmodule

/* design/alu_req_if.sv */
interface alu_req_if;

    import exu_pkg::*;

    alu_mode_e mode;
    xword_t    operand_a;
    xword_t    operand_b;
    // widening rule for the result side
    ext_kind_e ext_kind;

    modport req (output mode, operand_a, operand_b, ext_kind);

    modport alu (input mode, operand_a, operand_b);

    modport user (input ext_kind);

endinterface

/* design/ex_stage_if.sv */
interface ex_stage_if (input logic clk);

    import exu_pkg::*;

    // contents of the id/ex stage register
    logic    valid;
    xword_t  pc;
    inst_t   inst;
    // empty opcode whenever valid is low
    exu_op_e op;
    xword_t  src_a;
    xword_t  src_b;
    xword_t  imm;

    // written by the stage register
    modport stage (
        output valid, pc, inst, op, src_a, src_b, imm
    );

    // read by decode and result logic, clk for their checks
    modport sink (
        input clk, valid, pc, inst, op, src_a, src_b, imm
    );

endinterface

/* design/exu_pkg.sv */
package exu_pkg;

    // datapath and instruction widths
    localparam int xlen_w = 64;
    localparam int inst_w = 32;
    localparam int op_w   = 24;

    typedef logic [xlen_w-1:0] xword_t;
    typedef logic [inst_w-1:0] inst_t;

    // internal opcode handed over by the decode stage
    // codes match the ones the decode stage already emits
    typedef enum logic [op_w-1:0] {
        op_empty  = 24'h000000,
        op_lui    = 24'h000100,
        op_auipc  = 24'h000200,
        op_jal    = 24'h000300,
        op_slli   = 24'h000400,
        op_srli   = 24'h000800,
        op_srai   = 24'h000c00,
        op_jalr   = 24'd4,
        op_beq    = 24'd5,
        op_bne    = 24'd6,
        op_blt    = 24'd7,
        op_bge    = 24'd8,
        op_bltu   = 24'd9,
        op_bgeu   = 24'd10,
        // loads and stores only form an address here
        op_lb     = 24'd11,
        op_lh     = 24'd12,
        op_lw     = 24'd13,
        op_lbu    = 24'd14,
        op_lhu    = 24'd15,
        op_sb     = 24'd16,
        op_sh     = 24'd17,
        op_sw     = 24'd18,
        op_addi   = 24'd19,
        op_slti   = 24'd20,
        op_sltiu  = 24'd21,
        op_xori   = 24'd22,
        op_ori    = 24'd23,
        op_andi   = 24'd24,
        op_lwu    = 24'd41,
        op_ld     = 24'd42,
        op_sd     = 24'd43,
        op_addiw  = 24'd47,
        op_csrrw  = 24'd49,
        op_csrrs  = 24'd50,
        op_add    = 24'h004000,
        op_sub    = 24'h005000,
        op_sll    = 24'h006000,
        op_slt    = 24'h007000,
        op_sltu   = 24'h008000,
        op_xor    = 24'h009000,
        op_srl    = 24'h010000,
        op_or     = 24'h012000,
        op_and    = 24'h013000,
        op_slliw  = 24'h014000,
        op_srliw  = 24'h015000,
        op_sraiw  = 24'h016000,
        op_addw   = 24'h017000,
        op_subw   = 24'h018000,
        op_sllw   = 24'h019000,
        op_srlw   = 24'h01a000,
        op_sraw   = 24'h01b000,
        op_ecall  = 24'h200000,
        op_mret   = 24'h500000
    } exu_op_e;

    // alu operations, gaps kept from the old mode numbering
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_and  = 4'd4,
        alu_or   = 4'd6,
        alu_xor  = 4'd7,
        alu_sll  = 4'd8,
        alu_srl  = 4'd9,
        alu_sra  = 4'd10
    } alu_mode_e;

    // how a word-op result is widened back to 64 bits
    typedef enum logic [1:0] {
        ext_none    = 2'd0,
        ext_sext_lo = 2'd1,
        ext_sext_hi = 2'd2
    } ext_kind_e;

    // machine-mode csr numbers
    typedef enum logic [11:0] {
        csr_mstatus = 12'h300,
        csr_mtvec   = 12'h305,
        csr_mepc    = 12'h341,
        csr_mcause  = 12'h342
    } csr_addr_e;

    // sequential fetch step
    localparam xword_t pc_step = 64'd4;

endpackage
